//--- include/vcache_defines.svh
`ifndef VCACHE_DEFINES_SVH
`define VCACHE_DEFINES_SVH

// Word and network widths.
`define VCACHE_DATA_WIDTH 32
`define VCACHE_ADDR_WIDTH 16
`define VCACHE_SRC_ID_WIDTH 6
`define VCACHE_MASK_WIDTH (`VCACHE_DATA_WIDTH / 8)

// Cache geometry, fixed at two ways.
`define VCACHE_BLOCK_WORDS 4
`define VCACHE_SETS 8
`define VCACHE_WAYS 2

// One DMA beat carries one word.
`define VCACHE_DMA_DATA_WIDTH 32

// Address fields of a word address.
`define VCACHE_OFFSET_WIDTH $clog2(`VCACHE_BLOCK_WORDS)
`define VCACHE_INDEX_WIDTH $clog2(`VCACHE_SETS)
`define VCACHE_TAG_WIDTH \
  (`VCACHE_ADDR_WIDTH - `VCACHE_INDEX_WIDTH - `VCACHE_OFFSET_WIDTH)
`define VCACHE_BLOCK_ADDR_WIDTH (`VCACHE_ADDR_WIDTH - `VCACHE_OFFSET_WIDTH)

// Word slots in one way of the data array.
`define VCACHE_LINE_WORDS (`VCACHE_SETS * `VCACHE_BLOCK_WORDS)

`endif

//--- source/vcache_pkg.sv
package vcache_pkg;

  // Network and cache packet operation.
  typedef enum logic [0:0] {
    OP_LW = 1'b0,
    OP_SW = 1'b1
  } vcache_op_e;

  // Block transfer command on the DMA port.
  typedef enum logic [0:0] {
    DMA_READ  = 1'b0,
    DMA_WRITE = 1'b1
  } dma_cmd_e;

endpackage

//--- source/vcache_link_adapter.sv
`include "vcache_defines.svh"

module vcache_link_adapter (
  input  logic                              clk_i,
  input  logic                              reset_i,

  input  logic                              req_v_i,
  input  vcache_pkg::vcache_op_e            req_op_i,
  input  logic [`VCACHE_ADDR_WIDTH-1:0]     req_addr_i,
  input  logic [`VCACHE_DATA_WIDTH-1:0]     req_data_i,
  input  logic [`VCACHE_MASK_WIDTH-1:0]     req_mask_i,
  input  logic [`VCACHE_SRC_ID_WIDTH-1:0]   req_src_i,
  output logic                              req_ready_o,

  output logic                              rsp_v_o,
  output vcache_pkg::vcache_op_e            rsp_op_o,
  output logic [`VCACHE_DATA_WIDTH-1:0]     rsp_data_o,
  output logic [`VCACHE_SRC_ID_WIDTH-1:0]   rsp_src_o,
  input  logic                              rsp_ready_i,

  output logic                              cpkt_v_o,
  output vcache_pkg::vcache_op_e            cpkt_op_o,
  output logic [`VCACHE_ADDR_WIDTH-1:0]     cpkt_addr_o,
  output logic [`VCACHE_DATA_WIDTH-1:0]     cpkt_data_o,
  output logic [`VCACHE_MASK_WIDTH-1:0]     cpkt_mask_o,
  input  logic                              cpkt_yumi_i,

  input  logic                              cres_v_i,
  input  logic [`VCACHE_DATA_WIDTH-1:0]     cres_data_i,
  output logic                              cres_yumi_o
);

  logic                            pend_r;
  logic                            pkt_v_r;
  vcache_pkg::vcache_op_e          op_r;
  logic [`VCACHE_ADDR_WIDTH-1:0]   addr_r;
  logic [`VCACHE_DATA_WIDTH-1:0]   data_r;
  logic [`VCACHE_MASK_WIDTH-1:0]   mask_r;
  logic [`VCACHE_SRC_ID_WIDTH-1:0] src_r;
  logic                            req_fire;
  logic                            rsp_fire;

  // One request in flight from acceptance to response transfer.
  assign req_ready_o = ~pend_r & ~reset_i;
  assign req_fire    = req_v_i & req_ready_o;
  assign rsp_fire    = rsp_v_o & rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_r  <= 1'b0;
      pkt_v_r <= 1'b0;
    end else if (req_fire) begin
      pend_r  <= 1'b1;
      pkt_v_r <= 1'b1;
    end else begin
      if (cpkt_yumi_i) begin
        pkt_v_r <= 1'b0;
      end
      if (rsp_fire) begin
        pend_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      op_r   <= req_op_i;
      addr_r <= req_addr_i;
      data_r <= req_data_i;
      mask_r <= req_mask_i;
      src_r  <= req_src_i;
    end
  end

  // Packet stays offered until the cache takes it.
  assign cpkt_v_o    = pkt_v_r;
  assign cpkt_op_o   = op_r;
  assign cpkt_addr_o = addr_r;
  assign cpkt_data_o = data_r;
  assign cpkt_mask_o = mask_r;

  // The cache holds its result until yumi, so the response is stable.
  assign rsp_v_o   = cres_v_i;
  assign rsp_op_o  = op_r;
  assign rsp_src_o = src_r;

  // Store acknowledge carries a zero word.
  assign rsp_data_o = (op_r == vcache_pkg::OP_LW) ? cres_data_i : '0;

  assign cres_yumi_o = cres_v_i & rsp_ready_i;

endmodule

//--- source/vcache_blocking_cache.sv
`include "vcache_defines.svh"

module vcache_blocking_cache (
  input  logic                                clk_i,
  input  logic                                reset_i,

  input  logic                                cpkt_v_i,
  input  vcache_pkg::vcache_op_e              cpkt_op_i,
  input  logic [`VCACHE_ADDR_WIDTH-1:0]       cpkt_addr_i,
  input  logic [`VCACHE_DATA_WIDTH-1:0]       cpkt_data_i,
  input  logic [`VCACHE_MASK_WIDTH-1:0]       cpkt_mask_i,
  output logic                                cpkt_yumi_o,

  output logic                                cres_v_o,
  output logic [`VCACHE_DATA_WIDTH-1:0]       cres_data_o,
  input  logic                                cres_yumi_i,

  output logic                                dma_pkt_v_o,
  output vcache_pkg::dma_cmd_e                dma_pkt_cmd_o,
  output logic [`VCACHE_BLOCK_ADDR_WIDTH-1:0] dma_pkt_addr_o,
  input  logic                                dma_pkt_yumi_i,

  input  logic [`VCACHE_DMA_DATA_WIDTH-1:0]   dma_data_i,
  input  logic                                dma_data_v_i,
  output logic                                dma_data_ready_o,

  output logic [`VCACHE_DMA_DATA_WIDTH-1:0]   dma_data_o,
  output logic                                dma_data_v_o,
  input  logic                                dma_data_yumi_i
);

  localparam int unsigned offset_width_lp = `VCACHE_OFFSET_WIDTH;
  localparam int unsigned index_width_lp  = `VCACHE_INDEX_WIDTH;
  localparam int unsigned tag_width_lp    = `VCACHE_TAG_WIDTH;
  localparam logic [offset_width_lp-1:0] last_beat_lp =
    offset_width_lp'(`VCACHE_BLOCK_WORDS - 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_EVICT_CMD,
    ST_EVICT_DATA,
    ST_FILL_CMD,
    ST_FILL_DATA,
    ST_RESPOND
  } state_e;

  state_e state_r;
  state_e state_n;

  // Registered packet.
  vcache_pkg::vcache_op_e          op_r;
  logic [tag_width_lp-1:0]         tag_r;
  logic [index_width_lp-1:0]       idx_r;
  logic [offset_width_lp-1:0]      off_r;
  logic [`VCACHE_DATA_WIDTH-1:0]   data_r;
  logic [`VCACHE_MASK_WIDTH-1:0]   mask_r;
  logic [`VCACHE_DATA_WIDTH-1:0]   rdata_r;

  // Tag, state and data arrays.
  logic [tag_width_lp-1:0]             tag_mem  [`VCACHE_WAYS][`VCACHE_SETS];
  logic [`VCACHE_DATA_WIDTH-1:0]       data_mem [`VCACHE_WAYS][`VCACHE_LINE_WORDS];
  logic [`VCACHE_WAYS-1:0][`VCACHE_SETS-1:0] valid_r;
  logic [`VCACHE_WAYS-1:0][`VCACHE_SETS-1:0] dirty_r;
  logic [`VCACHE_SETS-1:0]             lru_r;

  logic [0:0]                          victim_r;
  logic [offset_width_lp-1:0]          cnt_r;

  logic                                hit0;
  logic                                hit1;
  logic                                hit;
  logic [0:0]                          hit_way;
  logic [0:0]                          alloc_way;
  logic                                victim_dirty;
  logic                                last_beat;
  logic [index_width_lp+offset_width_lp-1:0] line_word;
  logic [index_width_lp+offset_width_lp-1:0] beat_word;
  logic [`VCACHE_DATA_WIDTH-1:0]       old_word;
  logic [`VCACHE_DATA_WIDTH-1:0]       merged_word;

  assign hit0    = valid_r[0][idx_r] & (tag_mem[0][idx_r] == tag_r);
  assign hit1    = valid_r[1][idx_r] & (tag_mem[1][idx_r] == tag_r);
  assign hit     = hit0 | hit1;
  assign hit_way = hit1;

  // Invalid way first, then the LRU way.
  always_comb begin
    if (!valid_r[0][idx_r]) begin
      alloc_way = 1'b0;
    end else if (!valid_r[1][idx_r]) begin
      alloc_way = 1'b1;
    end else begin
      alloc_way = lru_r[idx_r];
    end
  end

  assign victim_dirty = valid_r[alloc_way][idx_r] & dirty_r[alloc_way][idx_r];
  assign last_beat    = (cnt_r == last_beat_lp);
  assign line_word    = {idx_r, off_r};
  assign beat_word    = {idx_r, cnt_r};
  assign old_word     = data_mem[hit_way][line_word];

  // Byte merge for stores.
  always_comb begin
    merged_word = old_word;
    for (int b = 0; b < `VCACHE_MASK_WIDTH; b++) begin
      if (mask_r[b]) begin
        merged_word[b*8 +: 8] = data_r[b*8 +: 8];
      end
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      ST_IDLE: begin
        if (cpkt_v_i) begin
          state_n = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (hit) begin
          state_n = ST_RESPOND;
        end else if (victim_dirty) begin
          state_n = ST_EVICT_CMD;
        end else begin
          state_n = ST_FILL_CMD;
        end
      end
      ST_EVICT_CMD: begin
        if (dma_pkt_yumi_i) begin
          state_n = ST_EVICT_DATA;
        end
      end
      ST_EVICT_DATA: begin
        if (dma_data_yumi_i && last_beat) begin
          state_n = ST_FILL_CMD;
        end
      end
      ST_FILL_CMD: begin
        if (dma_pkt_yumi_i) begin
          state_n = ST_FILL_DATA;
        end
      end
      ST_FILL_DATA: begin
        // Replay the lookup once the block is in.
        if (dma_data_v_i && last_beat) begin
          state_n = ST_LOOKUP;
        end
      end
      ST_RESPOND: begin
        if (cres_yumi_i) begin
          state_n = ST_IDLE;
        end
      end
      default: begin
        state_n = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= ST_IDLE;
      cnt_r    <= '0;
      victim_r <= 1'b0;
      valid_r  <= '0;
      dirty_r  <= '0;
      lru_r    <= '0;
    end else begin
      state_r <= state_n;
      case (state_r)
        ST_LOOKUP: begin
          if (hit) begin
            lru_r[idx_r] <= ~hit_way;
            if (op_r == vcache_pkg::OP_SW) begin
              dirty_r[hit_way][idx_r] <= 1'b1;
            end
          end else begin
            victim_r <= alloc_way;
          end
        end
        ST_EVICT_DATA: begin
          if (dma_data_yumi_i) begin
            cnt_r <= cnt_r + 1'b1;
          end
        end
        ST_FILL_DATA: begin
          if (dma_data_v_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_beat) begin
              valid_r[victim_r][idx_r] <= 1'b1;
              dirty_r[victim_r][idx_r] <= 1'b0;
            end
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (cpkt_yumi_o) begin
      op_r   <= cpkt_op_i;
      tag_r  <= cpkt_addr_i[`VCACHE_ADDR_WIDTH-1 -: tag_width_lp];
      idx_r  <= cpkt_addr_i[offset_width_lp +: index_width_lp];
      off_r  <= cpkt_addr_i[offset_width_lp-1:0];
      data_r <= cpkt_data_i;
      mask_r <= cpkt_mask_i;
    end
    if (state_r == ST_LOOKUP && hit) begin
      rdata_r <= old_word;
      if (op_r == vcache_pkg::OP_SW) begin
        data_mem[hit_way][line_word] <= merged_word;
      end
    end
    if (state_r == ST_FILL_DATA && dma_data_v_i) begin
      data_mem[victim_r][beat_word] <= dma_data_i;
      if (last_beat) begin
        tag_mem[victim_r][idx_r] <= tag_r;
      end
    end
  end

  assign cpkt_yumi_o = (state_r == ST_IDLE) & cpkt_v_i;

  assign cres_v_o    = (state_r == ST_RESPOND);
  assign cres_data_o = rdata_r;

  // Evict writes back the victim's old block address.
  assign dma_pkt_v_o   = (state_r == ST_EVICT_CMD) | (state_r == ST_FILL_CMD);
  assign dma_pkt_cmd_o = (state_r == ST_EVICT_CMD) ? vcache_pkg::DMA_WRITE
                                                   : vcache_pkg::DMA_READ;
  assign dma_pkt_addr_o = (state_r == ST_EVICT_CMD) ? {tag_mem[victim_r][idx_r], idx_r}
                                                    : {tag_r, idx_r};

  assign dma_data_v_o     = (state_r == ST_EVICT_DATA);
  assign dma_data_o       = data_mem[victim_r][beat_word];
  assign dma_data_ready_o = (state_r == ST_FILL_DATA);

endmodule

//--- source/vcache_tile.sv
`include "vcache_defines.svh"

module vcache_tile (
  input  logic                                clk_i,
  input  logic                                reset_i,

  input  logic                                req_v_i,
  input  vcache_pkg::vcache_op_e              req_op_i,
  input  logic [`VCACHE_ADDR_WIDTH-1:0]       req_addr_i,
  input  logic [`VCACHE_DATA_WIDTH-1:0]       req_data_i,
  input  logic [`VCACHE_MASK_WIDTH-1:0]       req_mask_i,
  input  logic [`VCACHE_SRC_ID_WIDTH-1:0]     req_src_i,
  output logic                                req_ready_o,

  output logic                                rsp_v_o,
  output vcache_pkg::vcache_op_e              rsp_op_o,
  output logic [`VCACHE_DATA_WIDTH-1:0]       rsp_data_o,
  output logic [`VCACHE_SRC_ID_WIDTH-1:0]     rsp_src_o,
  input  logic                                rsp_ready_i,

  output logic                                dma_pkt_v_o,
  output vcache_pkg::dma_cmd_e                dma_pkt_cmd_o,
  output logic [`VCACHE_BLOCK_ADDR_WIDTH-1:0] dma_pkt_addr_o,
  input  logic                                dma_pkt_yumi_i,

  input  logic [`VCACHE_DMA_DATA_WIDTH-1:0]   dma_data_i,
  input  logic                                dma_data_v_i,
  output logic                                dma_data_ready_o,

  output logic [`VCACHE_DMA_DATA_WIDTH-1:0]   dma_data_o,
  output logic                                dma_data_v_o,
  input  logic                                dma_data_yumi_i
);

  logic                          reset_r;

  logic                          cpkt_v;
  vcache_pkg::vcache_op_e        cpkt_op;
  logic [`VCACHE_ADDR_WIDTH-1:0] cpkt_addr;
  logic [`VCACHE_DATA_WIDTH-1:0] cpkt_data;
  logic [`VCACHE_MASK_WIDTH-1:0] cpkt_mask;
  logic                          cpkt_yumi;
  logic                          cres_v;
  logic [`VCACHE_DATA_WIDTH-1:0] cres_data;
  logic                          cres_yumi;

  // Reset is retimed once before it fans out.
  always_ff @(posedge clk_i) begin
    reset_r <= reset_i;
  end

  vcache_link_adapter link_adapter (
    .clk_i       (clk_i),
    .reset_i     (reset_r),
    .req_v_i     (req_v_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .req_mask_i  (req_mask_i),
    .req_src_i   (req_src_i),
    .req_ready_o (req_ready_o),
    .rsp_v_o     (rsp_v_o),
    .rsp_op_o    (rsp_op_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_src_o   (rsp_src_o),
    .rsp_ready_i (rsp_ready_i),
    .cpkt_v_o    (cpkt_v),
    .cpkt_op_o   (cpkt_op),
    .cpkt_addr_o (cpkt_addr),
    .cpkt_data_o (cpkt_data),
    .cpkt_mask_o (cpkt_mask),
    .cpkt_yumi_i (cpkt_yumi),
    .cres_v_i    (cres_v),
    .cres_data_i (cres_data),
    .cres_yumi_o (cres_yumi)
  );

  vcache_blocking_cache cache (
    .clk_i            (clk_i),
    .reset_i          (reset_r),
    .cpkt_v_i         (cpkt_v),
    .cpkt_op_i        (cpkt_op),
    .cpkt_addr_i      (cpkt_addr),
    .cpkt_data_i      (cpkt_data),
    .cpkt_mask_i      (cpkt_mask),
    .cpkt_yumi_o      (cpkt_yumi),
    .cres_v_o         (cres_v),
    .cres_data_o      (cres_data),
    .cres_yumi_i      (cres_yumi),
    .dma_pkt_v_o      (dma_pkt_v_o),
    .dma_pkt_cmd_o    (dma_pkt_cmd_o),
    .dma_pkt_addr_o   (dma_pkt_addr_o),
    .dma_pkt_yumi_i   (dma_pkt_yumi_i),
    .dma_data_i       (dma_data_i),
    .dma_data_v_i     (dma_data_v_i),
    .dma_data_ready_o (dma_data_ready_o),
    .dma_data_o       (dma_data_o),
    .dma_data_v_o     (dma_data_v_o),
    .dma_data_yumi_i  (dma_data_yumi_i)
  );

endmodule

//--- tb/vcache_mem_model.sv
`include "vcache_defines.svh"

module vcache_mem_model #(
  parameter logic [31:0] seed_p = 32'h1f3b_3854
) (
  input  logic                                clk_i,
  input  logic                                reset_i,

  input  logic                                dma_pkt_v_i,
  input  vcache_pkg::dma_cmd_e                dma_pkt_cmd_i,
  input  logic [`VCACHE_BLOCK_ADDR_WIDTH-1:0] dma_pkt_addr_i,
  output logic                                dma_pkt_yumi_o,

  output logic [`VCACHE_DMA_DATA_WIDTH-1:0]   dma_data_o,
  output logic                                dma_data_v_o,
  input  logic                                dma_data_ready_i,

  input  logic [`VCACHE_DMA_DATA_WIDTH-1:0]   dma_data_i,
  input  logic                                dma_data_v_i,
  output logic                                dma_data_yumi_o,

  output logic                                fault_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [`VCACHE_DATA_WIDTH-1:0] mem_r [2**`VCACHE_ADDR_WIDTH];
  logic [31:0]                   lfsr_r;

  // Power-on contents, a fixed pattern of the word address.
  function automatic logic [31:0] init_word(input logic [15:0] a);
    return {~a, a} ^ 32'h3c96_a5e1;
  endfunction

  // Galois LFSR, one step per bit taken.
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], lfsr_r[0]};
      lfsr_r = (lfsr_r >> 1) ^ (lfsr_r[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  task automatic random_gap();
    repeat (rand_bits(2)) @(negedge clk_i);
  endtask

  initial begin
    vcache_pkg::dma_cmd_e                cmd;
    logic [`VCACHE_ADDR_WIDTH-1:0]       base;
    int                                  waited;
    lfsr_r = seed_p;
    for (int a = 0; a < 2**`VCACHE_ADDR_WIDTH; a++) begin
      mem_r[a] = init_word(a[15:0]);
    end
    dma_pkt_yumi_o  = 1'b0;
    dma_data_o      = '0;
    dma_data_v_o    = 1'b0;
    dma_data_yumi_o = 1'b0;
    fault_o         = 1'b0;
    forever begin
      @(negedge clk_i);
      if (!reset_i && dma_pkt_v_i) begin
        random_gap();
        cmd  = dma_pkt_cmd_i;
        base = {dma_pkt_addr_i, 2'b00};
        dma_pkt_yumi_o = 1'b1;
        @(negedge clk_i);
        dma_pkt_yumi_o = 1'b0;
        for (int beat = 0; beat < `VCACHE_BLOCK_WORDS; beat++) begin
          random_gap();
          if (cmd == vcache_pkg::DMA_WRITE) begin
            waited = 0;
            while (!dma_data_v_i && waited < 100) begin
              @(negedge clk_i);
              waited++;
            end
            if (!dma_data_v_i) begin
              fault_o = 1'b1;
            end
            mem_r[base + beat] = dma_data_i;
            dma_data_yumi_o = 1'b1;
            @(negedge clk_i);
            dma_data_yumi_o = 1'b0;
          end else begin
            if (!dma_data_ready_i) begin
              fault_o = 1'b1;
            end
            dma_data_o   = mem_r[base + beat];
            dma_data_v_o = 1'b1;
            @(negedge clk_i);
            dma_data_v_o = 1'b0;
          end
        end
      end
    end
  end

endmodule

//--- tb/vcache_tb.sv
`include "vcache_defines.svh"

module vcache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_lp = 2000;

  logic clk_i;
  logic reset_i;
  logic req_v_i;
  vcache_pkg::vcache_op_e req_op_i;
  logic [`VCACHE_ADDR_WIDTH-1:0] req_addr_i;
  logic [`VCACHE_DATA_WIDTH-1:0] req_data_i;
  logic [`VCACHE_MASK_WIDTH-1:0] req_mask_i;
  logic [`VCACHE_SRC_ID_WIDTH-1:0] req_src_i;
  logic req_ready_o;
  logic rsp_v_o;
  vcache_pkg::vcache_op_e rsp_op_o;
  logic [`VCACHE_DATA_WIDTH-1:0] rsp_data_o;
  logic [`VCACHE_SRC_ID_WIDTH-1:0] rsp_src_o;
  logic rsp_ready_i;
  logic dma_pkt_v_o;
  vcache_pkg::dma_cmd_e dma_pkt_cmd_o;
  logic [`VCACHE_BLOCK_ADDR_WIDTH-1:0] dma_pkt_addr_o;
  logic dma_pkt_yumi_i;
  logic [`VCACHE_DMA_DATA_WIDTH-1:0] dma_data_i;
  logic dma_data_v_i;
  logic dma_data_ready_o;
  logic [`VCACHE_DMA_DATA_WIDTH-1:0] dma_data_o;
  logic dma_data_v_o;
  logic dma_data_yumi_i;
  logic mem_fault;

  logic [31:0] lfsr_r;
  logic [31:0] stall_lfsr_r;
  logic [`VCACHE_DATA_WIDTH-1:0] ref_mem [2**`VCACHE_ADDR_WIDTH];
  logic [`VCACHE_DATA_WIDTH-1:0] exp_data_q[$];
  logic [`VCACHE_SRC_ID_WIDTH-1:0] exp_src_q[$];
  vcache_pkg::vcache_op_e exp_op_q[$];
  logic [`VCACHE_BLOCK_ADDR_WIDTH-1:0] last_fill_addr;

  vcache_tile dut_i (.*);

  vcache_mem_model mem (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .dma_pkt_v_i      (dma_pkt_v_o),
    .dma_pkt_cmd_i    (dma_pkt_cmd_o),
    .dma_pkt_addr_i   (dma_pkt_addr_o),
    .dma_pkt_yumi_o   (dma_pkt_yumi_i),
    .dma_data_o       (dma_data_i),
    .dma_data_v_o     (dma_data_v_i),
    .dma_data_ready_i (dma_data_ready_o),
    .dma_data_i       (dma_data_o),
    .dma_data_v_i     (dma_data_v_o),
    .dma_data_yumi_o  (dma_data_yumi_i),
    .fault_o          (mem_fault)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [7:0] rand_bits(inout logic [31:0] state, input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], state[0]};
      state = (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic logic [31:0] rand_word();
    return {rand_bits(lfsr_r, 8), rand_bits(lfsr_r, 8), rand_bits(lfsr_r, 8),
            rand_bits(lfsr_r, 8)};
  endfunction

  // Loads read the reference array and stores merge bytes into it.
  function automatic logic [31:0] ref_access(input vcache_pkg::vcache_op_e op,
                                             input logic [15:0] addr,
                                             input logic [31:0] data,
                                             input logic [3:0] mask);
    logic [31:0] w;
    w = ref_mem[addr];
    if (op == vcache_pkg::OP_LW) begin
      return w;
    end
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        w[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    ref_mem[addr] = w;
    return 32'h0;
  endfunction

  task automatic stop_run(input string what);
    $display("Checks failed");
    $fatal(1, "%s", what);
  endtask

  task automatic check_data(input string name, input logic [`VCACHE_DATA_WIDTH-1:0] got,
                            input logic [`VCACHE_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%h exp=%h", $time, name, got, exp);
      stop_run("data mismatch");
    end
  endtask

  task automatic check_src(input string name, input logic [`VCACHE_SRC_ID_WIDTH-1:0] got,
                           input logic [`VCACHE_SRC_ID_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%h exp=%h", $time, name, got, exp);
      stop_run("source id mismatch");
    end
  endtask

  task automatic check_op(input string name, input vcache_pkg::vcache_op_e got,
                          input vcache_pkg::vcache_op_e exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%s exp=%s", $time, name, got.name(), exp.name());
      stop_run("operation mismatch");
    end
  endtask

  task automatic check_blk_addr(input string name,
                                input logic [`VCACHE_BLOCK_ADDR_WIDTH-1:0] got,
                                input logic [`VCACHE_BLOCK_ADDR_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%h exp=%h", $time, name, got, exp);
      stop_run("DMA block address mismatch");
    end
  endtask

  task automatic check_quiet();
    if (rsp_v_o !== 1'b0 || dma_pkt_v_o !== 1'b0 || dma_data_v_o !== 1'b0 ||
        dma_data_ready_o !== 1'b0) begin
      stop_run("a valid output was active with no request sent");
    end
  endtask

  task automatic send_req(input vcache_pkg::vcache_op_e op, input logic [15:0] addr,
                          input logic [31:0] data, input logic [3:0] mask,
                          input logic [5:0] src);
    int waited;
    waited = 0;
    @(negedge clk_i);
    req_v_i    = 1'b1;
    req_op_i   = op;
    req_addr_i = addr;
    req_data_i = data;
    req_mask_i = mask;
    req_src_i  = src;
    forever begin
      @(posedge clk_i);
      if (req_ready_o === 1'b1) break;
      waited++;
      if (waited > timeout_lp) stop_run("request was never accepted");
    end
    exp_data_q.push_back(ref_access(op, addr, data, mask));
    exp_src_q.push_back(src);
    exp_op_q.push_back(op);
    @(negedge clk_i);
    req_v_i = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_op_q.size() != 0) begin
      @(posedge clk_i);
      waited++;
      if (waited > timeout_lp) stop_run("responses did not arrive in time");
    end
  endtask

  always @(posedge clk_i) begin
    if (dma_pkt_v_o === 1'b1 && dma_pkt_yumi_i && dma_pkt_cmd_o == vcache_pkg::DMA_READ) begin
      last_fill_addr <= dma_pkt_addr_o;
    end
  end

  // Response checker with hold stability under back-pressure.
  initial begin
    logic held;
    logic [`VCACHE_DATA_WIDTH-1:0] held_data;
    logic [`VCACHE_SRC_ID_WIDTH-1:0] held_src;
    held = 1'b0;
    forever begin
      @(posedge clk_i);
      if (mem_fault) stop_run("memory model saw a broken DMA transfer");
      if (held) begin
        if (rsp_v_o !== 1'b1) stop_run("response valid dropped before transfer");
        check_data("rsp_data_o", rsp_data_o, held_data);
        check_src("rsp_src_o", rsp_src_o, held_src);
      end
      if (rsp_v_o === 1'b1 && rsp_ready_i) begin
        if (exp_op_q.size() == 0) stop_run("response with no request outstanding");
        check_data("rsp_data_o", rsp_data_o, exp_data_q.pop_front());
        check_src("rsp_src_o", rsp_src_o, exp_src_q.pop_front());
        check_op("rsp_op_o", rsp_op_o, exp_op_q.pop_front());
        held = 1'b0;
      end else if (rsp_v_o === 1'b1) begin
        held      = 1'b1;
        held_data = rsp_data_o;
        held_src  = rsp_src_o;
      end else begin
        held = 1'b0;
      end
    end
  end

  // Random stalls on the response channel.
  initial begin
    @(negedge reset_i);
    forever begin
      @(negedge clk_i);
      rsp_ready_i = (rand_bits(stall_lfsr_r, 2) != 0);
    end
  end

  initial begin
    logic [15:0] a;
    lfsr_r       = 32'h1f3b_3854;
    stall_lfsr_r = 32'h1f3b_3854;
    reset_i      = 1'b1;
    req_v_i      = 1'b0;
    req_op_i     = vcache_pkg::OP_LW;
    req_addr_i   = '0;
    req_data_i   = '0;
    req_mask_i   = '0;
    req_src_i    = '0;
    rsp_ready_i  = 1'b0;
    for (int i = 0; i < 2**`VCACHE_ADDR_WIDTH; i++) begin
      ref_mem[i] = {~i[15:0], i[15:0]} ^ 32'h3c96_a5e1;
    end
    for (int c = 0; c < 8; c++) begin
      @(posedge clk_i);
      if (c >= 2) begin
        check_quiet();
        if (req_ready_o !== 1'b0) stop_run("request ready was high during reset");
      end
    end
    @(negedge clk_i);
    reset_i = 1'b0;
    repeat (4) begin
      @(posedge clk_i);
      check_quiet();
    end

    // Cold load misses.
    send_req(vcache_pkg::OP_LW, 16'h0042, '0, '0, 6'd1);
    drain();
    check_blk_addr("dma_pkt_addr_o", last_fill_addr, 14'h0010);
    send_req(vcache_pkg::OP_LW, 16'h1235, '0, '0, 6'd2);
    drain();
    check_blk_addr("dma_pkt_addr_o", last_fill_addr, 14'h048d);

    // Partial store and loads in the same block.
    send_req(vcache_pkg::OP_SW, 16'h0041, 32'hdead_beef, 4'b0101, 6'd3);
    send_req(vcache_pkg::OP_LW, 16'h0041, '0, '0, 6'd4);
    send_req(vcache_pkg::OP_LW, 16'h0040, '0, '0, 6'd5);
    send_req(vcache_pkg::OP_LW, 16'h0043, '0, '0, 6'd6);
    drain();

    // Three blocks in set 3 force dirty evictions.
    for (int k = 0; k < 3; k++) begin
      send_req(vcache_pkg::OP_SW, 16'h010d + 16'(k * 32), 32'h1000_0000 + k, 4'hf, 6'(k));
    end
    for (int k = 0; k < 3; k++) begin
      send_req(vcache_pkg::OP_LW, 16'h010d + 16'(k * 32), '0, '0, 6'(k + 8));
    end
    drain();
    for (int k = 0; k < 3; k++) begin
      for (int w = 0; w < 4; w++) begin
        a = 16'h010c + 16'(k * 32 + w);
        check_data("mem word", mem.mem_r[a], ref_mem[a]);
      end
    end

    // Random mixed traffic.
    for (int n = 0; n < 200; n++) begin
      a = {7'h0, 8'(rand_bits(lfsr_r, 8)), 1'(rand_bits(lfsr_r, 1))};
      if (rand_bits(lfsr_r, 1) != 0) begin
        send_req(vcache_pkg::OP_SW, a, rand_word(), 4'(rand_bits(lfsr_r, 4)),
                 6'(rand_bits(lfsr_r, 6)));
      end else begin
        send_req(vcache_pkg::OP_LW, a, rand_word(), 4'(rand_bits(lfsr_r, 4)),
                 6'(rand_bits(lfsr_r, 6)));
      end
    end
    drain();

    $display("All checks passed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
source/vcache_pkg.sv
source/vcache_link_adapter.sv
source/vcache_blocking_cache.sv
source/vcache_tile.sv
tb/vcache_mem_model.sv
tb/vcache_tb.sv

//--- Bender.yml
package:
  name: vcache_tile

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/vcache_pkg.sv
      - source/vcache_link_adapter.sv
      - source/vcache_blocking_cache.sv
      - source/vcache_tile.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/vcache_mem_model.sv
      - tb/vcache_tb.sv
